//--- build.f
+incdir+source
source/video_pkg.sv
source/pixel_input.sv
source/scan_timing.sv
source/pixel_scanout.sv
source/video_top.sv
sim/video_tb.sv

//--- Makefile
SOURCES := $(shell grep -v '^+' build.f) source/video_params.svh

.PHONY: all run clean

all: run

obj_dir/Vvideo_tb: build.f $(SOURCES)
	verilator --binary --timing --assert -f build.f --top-module video_tb -o Vvideo_tb

run: obj_dir/Vvideo_tb
	@out="$$(./obj_dir/Vvideo_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- sim/video_tb.sv
`timescale 1ns/100ps

`include "video_params.svh"

module video_tb;

	localparam int FRAME_CYCLES = `VID_HLINE * `VID_VLINE;
	localparam int RUN_CYCLES   = 3 * FRAME_CYCLES;
	localparam int TIMEOUT      = RUN_CYCLES + 100;
	// counter position (0,0) shows on o_video after the third edge past reset.
	localparam int LATENCY      = 3;
	localparam int PIX_W        = 3 * `VID_COLOR_W;

	logic              i_clock_out;
	logic              i_reset;
	logic              i_pixel_valid;
	video_pkg::pixel_t i_pixel;
	logic              o_credit;
	video_pkg::video_t o_video;
	logic              o_underflow;

	integer            seed;
	int                errors;
	int                checks;
	int                cycles;
	int                credits;
	int                credit_pulses;
	int                consumed;
	int                sent;
	logic              model_underflow;
	logic              last_valid;
	video_pkg::pixel_t last_pixel;
	video_pkg::pixel_t model_q[$];

	video_top uut (
		.i_clock_out   (i_clock_out),
		.i_reset       (i_reset),
		.i_pixel_valid (i_pixel_valid),
		.i_pixel       (i_pixel),
		.o_credit      (o_credit),
		.o_video       (o_video),
		.o_underflow   (o_underflow)
	);

	always #20 i_clock_out = ~i_clock_out;

	// ends a run that never reaches its last frame.
	always @(posedge i_clock_out) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("Test failures found");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [63:0] observed,
		input logic [63:0] expected);
		checks = checks + 1;
		if (observed !== expected) begin
			errors = errors + 1;
			$display("mismatch at %0t: %s observed %0h expected %0h",
				$time, name, observed, expected);
		end
	endtask

	task automatic check_idle_outputs();
		check_value("o_video", 64'(o_video), 64'd0);
		check_value("o_credit", 64'(o_credit), 64'd0);
		check_value("o_underflow", 64'(o_underflow), 64'd0);
	endtask

	// raster and pixel model for the edge that produced the current o_video.
	task automatic compare_raster(input int r);
		int                     h;
		int                     v;
		logic                   exp_hs;
		logic                   exp_vs;
		logic                   exp_de;
		logic                   exp_pop;
		logic [`VID_POS_W-1:0]  exp_x;
		logic [`VID_POS_W-1:0]  exp_y;
		video_pkg::pixel_t      exp_pixel;
		h = r % `VID_HLINE;
		v = (r / `VID_HLINE) % `VID_VLINE;
		exp_hs = (h >= `VID_HLINE - `VID_HPULSE);
		exp_vs = (v >= `VID_VLINE - `VID_VPULSE);
		exp_de = (h >= `VID_HBACK) && (h < `VID_HLINE - `VID_HPULSE - `VID_HFRONT) &&
			(v >= `VID_VBACK) && (v < `VID_VLINE - `VID_VPULSE - `VID_VFRONT);
		exp_x = `VID_POS_W'(h - `VID_HBACK);
		exp_y = `VID_POS_W'(v - `VID_VBACK);
		exp_pixel = '0;
		exp_pop = 1'b0;
		if (exp_de) begin
			if (model_q.size() > 0) begin
				exp_pixel = model_q.pop_front();
				exp_pop = 1'b1;
				consumed = consumed + 1;
			end else begin
				model_underflow = 1'b1;
			end
		end
		check_value("hsync", 64'(o_video.hsync), 64'(exp_hs));
		check_value("vsync", 64'(o_video.vsync), 64'(exp_vs));
		check_value("de", 64'(o_video.de), 64'(exp_de));
		if (exp_de) begin
			check_value("pos_x", 64'(o_video.pos_x), 64'(exp_x));
			check_value("pos_y", 64'(o_video.pos_y), 64'(exp_y));
		end
		check_value("pixel", 64'(o_video.pixel), 64'(exp_pixel));
		// credit comes back in the cycle after the pop.
		check_value("o_credit", 64'(o_credit), 64'(exp_pop));
		check_value("o_underflow", 64'(o_underflow), 64'(model_underflow));
	endtask

	// random sender that spends one credit per pixel.
	task automatic drive_sender(input int c);
		logic [31:0] coin;
		logic [31:0] data;
		logic        withhold;
		int          r;
		if (o_credit) begin
			credits = credits + 1;
			credit_pulses = credit_pulses + 1;
		end
		if (credits < 0 || credits > `VID_FIFO_DEPTH) begin
			errors = errors + 1;
			$display("sender credit count out of range at %0t: %0d", $time, credits);
		end
		r = c - LATENCY;
		// line 4 of the third frame gets no pixels, so the fifo runs dry.
		withhold = (r >= 2 * FRAME_CYCLES) && (r < 3 * FRAME_CYCLES) &&
			(((r % FRAME_CYCLES) / `VID_HLINE) == 4);
		coin = $random(seed);
		data = $random(seed);
		i_pixel_valid = 1'b0;
		if (credits > 0 && coin[0] && !withhold) begin
			i_pixel_valid = 1'b1;
			i_pixel = data[PIX_W-1:0];
			credits = credits - 1;
			sent = sent + 1;
		end
	endtask

	initial begin
		int c;
		seed = 37;
		errors = 0;
		checks = 0;
		cycles = 0;
		credits = `VID_FIFO_DEPTH;
		credit_pulses = 0;
		consumed = 0;
		sent = 0;
		model_underflow = 1'b0;
		last_valid = 1'b0;
		last_pixel = '0;
		i_clock_out = 1'b0;
		i_reset = 1'b1;
		i_pixel_valid = 1'b0;
		i_pixel = '0;

		repeat (8) begin
			@(negedge i_clock_out);
			check_idle_outputs();
		end
		i_reset = 1'b0;
		drive_sender(0);
		last_valid = i_pixel_valid;
		last_pixel = i_pixel;

		for (c = 1; c < LATENCY + RUN_CYCLES; c++) begin
			@(negedge i_clock_out);
			if (c == 1) begin
				check_idle_outputs();
			end else if (c >= LATENCY) begin
				compare_raster(c - LATENCY);
			end else begin
				check_value("o_credit", 64'(o_credit), 64'd0);
				check_value("o_underflow", 64'(o_underflow), 64'd0);
			end
			// a pixel written at this edge is only poppable from the next one.
			if (last_valid) begin
				model_q.push_back(last_pixel);
			end
			drive_sender(c);
			last_valid = i_pixel_valid;
			last_pixel = i_pixel;
		end

		@(negedge i_clock_out);
		i_pixel_valid = 1'b0;
		check_value("credit pulses", 64'(credit_pulses), 64'(consumed));
		if (!model_underflow) begin
			errors = errors + 1;
			$display("the withheld line did not cause an underflow");
		end

		$display("sent: %0d, consumed: %0d, checks: %0d, errors: %0d",
			sent, consumed, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- source/video_top.sv
`timescale 1ns/100ps

module video_top (
	input  logic              i_clock_out,
	input  logic              i_reset,
	input  logic              i_pixel_valid,
	input  video_pkg::pixel_t i_pixel,
	output logic              o_credit,
	output video_pkg::video_t o_video,
	output logic              o_underflow
);
	video_pkg::scan_t  scan;
	video_pkg::pixel_t head;
	logic              pop;
	logic              empty;

	// host side pixel fifo.
	pixel_input u_pixel_input (
		.i_clock_out   (i_clock_out),
		.i_reset       (i_reset),
		.i_pixel_valid (i_pixel_valid),
		.i_pixel       (i_pixel),
		.i_pop         (pop),
		.o_head        (head),
		.o_empty       (empty),
		.o_credit      (o_credit)
	);

	scan_timing u_scan_timing (
		.i_clock_out (i_clock_out),
		.i_reset     (i_reset),
		.o_scan      (scan)
	);

	// output side, one clock behind the scan.
	pixel_scanout u_pixel_scanout (
		.i_clock_out (i_clock_out),
		.i_reset     (i_reset),
		.i_scan      (scan),
		.i_head      (head),
		.i_empty     (empty),
		.o_pop       (pop),
		.o_video     (o_video),
		.o_underflow (o_underflow)
	);

endmodule

//--- source/pixel_scanout.sv
`timescale 1ns/100ps

`include "video_params.svh"

module pixel_scanout (
	input  logic              i_clock_out,
	input  logic              i_reset,
	input  video_pkg::scan_t  i_scan,
	input  video_pkg::pixel_t i_head,
	input  logic              i_empty,
	output logic              o_pop,
	output video_pkg::video_t o_video,
	output logic              o_underflow
);
	localparam int POS_W    = `VID_POS_W;
	localparam int H_ACTIVE = `VID_HLINE - `VID_HBACK - `VID_HPULSE - `VID_HFRONT;
	localparam int V_ACTIVE = `VID_VLINE - `VID_VBACK - `VID_VPULSE - `VID_VFRONT;

	logic starved;

	// consume one pixel for each active position while data is there.
	assign o_pop   = i_scan.active && !i_empty;
	assign starved = i_scan.active && i_empty;

	always_ff @(posedge i_clock_out) begin
		if (i_reset) begin
			o_video <= '0;
		end else begin
			o_video.hsync <= i_scan.hsync;
			o_video.vsync <= i_scan.vsync;
			o_video.de    <= i_scan.active;
			o_video.pos_x <= i_scan.pos_x;
			o_video.pos_y <= i_scan.pos_y;
			// black when there is nothing to show.
			if (o_pop) begin
				o_video.pixel <= i_head;
			end else begin
				o_video.pixel <= '0;
			end
		end
	end

	// sticky until the next reset.
	always_ff @(posedge i_clock_out) begin
		if (i_reset) begin
			o_underflow <= 1'b0;
		end else if (starved) begin
			o_underflow <= 1'b1;
		end
	end

	// a pixel is only consumed at a position inside the visible area.
	a_pop_in_active: assert property (
		@(posedge i_clock_out) disable iff (i_reset)
		o_pop |-> (i_scan.pos_x < POS_W'(H_ACTIVE)) && (i_scan.pos_y < POS_W'(V_ACTIVE))
	) else $error("pixel_scanout: pop outside an active position");

endmodule

//--- source/scan_timing.sv
`timescale 1ns/100ps

`include "video_params.svh"

module scan_timing (
	input  logic             i_clock_out,
	input  logic             i_reset,
	output video_pkg::scan_t o_scan
);
	localparam int POS_W = `VID_POS_W;

	localparam int H_SYNC_START = `VID_HLINE - `VID_HPULSE;
	localparam int V_SYNC_START = `VID_VLINE - `VID_VPULSE;
	localparam int H_WIN_END    = `VID_HLINE - `VID_HPULSE - `VID_HFRONT;
	localparam int V_WIN_END    = `VID_VLINE - `VID_VPULSE - `VID_VFRONT;

	logic [POS_W-1:0] h_count;
	logic [POS_W-1:0] v_count;

	// first pipeline stage.
	logic             hsync_a;
	logic             vsync_a;
	logic             hwin_a;
	logic             vwin_a;
	logic [POS_W-1:0] h_a;
	logic [POS_W-1:0] v_a;

	// raster counters, vertical steps when horizontal wraps.
	always_ff @(posedge i_clock_out) begin
		if (i_reset) begin
			h_count <= '0;
			v_count <= '0;
		end else if (h_count == POS_W'(`VID_HLINE - 1)) begin
			h_count <= '0;
			if (v_count == POS_W'(`VID_VLINE - 1)) begin
				v_count <= '0;
			end else begin
				v_count <= v_count + 1'b1;
			end
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	// decode sync and window flags from the raw counts.
	always_ff @(posedge i_clock_out) begin
		if (i_reset) begin
			hsync_a <= 1'b0;
			vsync_a <= 1'b0;
			hwin_a  <= 1'b0;
			vwin_a  <= 1'b0;
			h_a     <= '0;
			v_a     <= '0;
		end else begin
			hsync_a <= (h_count >= POS_W'(H_SYNC_START));
			vsync_a <= (v_count >= POS_W'(V_SYNC_START));
			hwin_a  <= (h_count >= POS_W'(`VID_HBACK)) && (h_count < POS_W'(H_WIN_END));
			vwin_a  <= (v_count >= POS_W'(`VID_VBACK)) && (v_count < POS_W'(V_WIN_END));
			h_a     <= h_count;
			v_a     <= v_count;
		end
	end

	// second stage combines the windows and moves the origin to the first active pixel.
	always_ff @(posedge i_clock_out) begin
		if (i_reset) begin
			o_scan <= '0;
		end else begin
			o_scan.hsync  <= hsync_a;
			o_scan.vsync  <= vsync_a;
			o_scan.active <= hwin_a && vwin_a;
			o_scan.pos_x  <= h_a - POS_W'(`VID_HBACK);
			o_scan.pos_y  <= v_a - POS_W'(`VID_VBACK);
		end
	end

	// inside an active run the horizontal position steps by one pixel per clock.
	a_pos_step: assert property (
		@(posedge i_clock_out) disable iff (i_reset)
		o_scan.active && $past(o_scan.active) |-> o_scan.pos_x == $past(o_scan.pos_x) + 1'b1
	) else $error("scan_timing: pos_x does not step within an active run");

endmodule

//--- source/pixel_input.sv
`timescale 1ns/100ps

`include "video_params.svh"

module pixel_input (
	input  logic              i_clock_out,
	input  logic              i_reset,
	input  logic              i_pixel_valid,
	input  video_pkg::pixel_t i_pixel,
	input  logic              i_pop,
	output video_pkg::pixel_t o_head,
	output logic              o_empty,
	output logic              o_credit
);
	localparam int DEPTH = `VID_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	video_pkg::pixel_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;
	logic             full;
	logic             wr_en;
	logic             rd_en;

	assign full    = (fill == CNT_W'(DEPTH));
	assign o_empty = (fill == '0);
	// head is read straight from storage, no read latency.
	assign o_head  = mem[rd_ptr];

	assign wr_en = i_pixel_valid;
	assign rd_en = i_pop && !o_empty;

	// payload storage.
	always_ff @(posedge i_clock_out) begin
		if (wr_en) begin
			mem[wr_ptr] <= i_pixel;
		end
	end

	always_ff @(posedge i_clock_out) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	// one credit goes back to the host for every pixel released.
	always_ff @(posedge i_clock_out) begin
		if (i_reset) begin
			o_credit <= 1'b0;
		end else begin
			o_credit <= rd_en;
		end
	end

	// the host only sends while it holds a credit, so a full fifo never sees a write.
	a_no_overfill: assert property (
		@(posedge i_clock_out) disable iff (i_reset)
		!(i_pixel_valid && full)
	) else $error("pixel_input: write while full, host credit violation");

endmodule

//--- source/video_pkg.sv
`include "video_params.svh"

package video_pkg;

	// one rgb pixel.
	typedef struct packed {
		logic [`VID_COLOR_W-1:0] red;
		logic [`VID_COLOR_W-1:0] green;
		logic [`VID_COLOR_W-1:0] blue;
	} pixel_t;

	// decoded state of one raster position.
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic active;
		logic [`VID_POS_W-1:0] pos_x;
		logic [`VID_POS_W-1:0] pos_y;
	} scan_t;

	// registered output word.
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
		logic [`VID_POS_W-1:0] pos_x;
		logic [`VID_POS_W-1:0] pos_y;
		pixel_t pixel;
	} video_t;

endpackage

//--- source/video_params.svh
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// horizontal raster geometry in clocks.
`define VID_HLINE 24
`define VID_HBACK 3
`define VID_HFRONT 2
`define VID_HPULSE 3

// vertical raster geometry in lines.
`define VID_VLINE 14
`define VID_VBACK 2
`define VID_VFRONT 1
`define VID_VPULSE 1

// counter and position width.
`define VID_POS_W 11

// bits per colour channel.
`define VID_COLOR_W 4

// pixel fifo entries, also the initial host credit.
`define VID_FIFO_DEPTH 8

`endif
